/* filelist.f */
rtl/fetch_pkg.sv
rtl/fetch_if.sv
rtl/bus_fetch_fsm.sv
rtl/bus_wait_timer.sv
rtl/pc_unit.sv
rtl/inst_latch.sv
rtl/fetch_top.sv
tb/tb_fetch.sv

/* rtl/bus_fetch_fsm.sv */
// bus fetch request machine
`timescale 1ns/1ps
`default_nettype none

module bus_fetch_fsm import fetch_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     stall,
	input  logic     ack,
	input  logic     timer_expired,
	output logic     timer_run,
	output logic     cyc,
	output logic     stb,
	fetch_ctl_if.fsm ctl
);

	logic [1:0] state;
	logic [1:0] state_next;
	logic       in_req;

	// state register
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// next state
	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				// stall only delays the next request
				if (!stall) begin
					state_next = ST_REQ;
				end
			end
			ST_REQ: begin
				// ack wins over a timeout in the same cycle
				if (ack) begin
					state_next = ST_DONE;
				end else if (timer_expired) begin
					state_next = ST_DROP;
				end
			end
			ST_DROP: begin
				// one cycle with cyc/stb low, then reissue same address
				state_next = ST_REQ;
			end
			ST_DONE: begin
				state_next = ST_IDLE;
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	assign in_req = (state == ST_REQ);

	// cyc and stb rise and fall together
	assign cyc = in_req;
	assign stb = in_req;

	// ack outside a strobe is ignored
	assign ctl.ack_fire = ack & in_req;
	assign ctl.fetch_done = (state == ST_DONE);

	// wait timer only runs while a request is on the bus
	assign timer_run = in_req;

endmodule

`default_nettype wire

/* rtl/bus_wait_timer.sv */
// bus ack wait timer
`timescale 1ns/1ps
`default_nettype none

module bus_wait_timer import fetch_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic run,
	output logic expired
);

	// wait cycles already spent in this request
	logic [TIMER_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (!run) begin
			count <= '0;
		end else begin
			count <= count + TIMER_W'(1);
		end
	end

	// high in the last allowed wait cycle
	// so stb stays up for exactly BUS_TIMEOUT cycles
	assign expired = run && (count == TIMER_W'(BUS_TIMEOUT - 1));

endmodule

`default_nettype wire

/* rtl/fetch_if.sv */
// fetch control interface
`timescale 1ns/1ps
`default_nettype none

interface fetch_ctl_if import fetch_pkg::*; ();

	// address of the current request
	logic [XLEN-1:0] fetch_pc;
	// ack while stb is high
	logic ack_fire;
	// returned read data
	logic [XLEN-1:0] bus_word;
	// in-flight fetch was redirected
	logic kill;
	// one-cycle done state
	logic fetch_done;

	// request sequencing
	modport fsm (
		output ack_fire,
		output fetch_done
	);

	// pc register and next-pc select
	modport pc (
		input  ack_fire,
		input  bus_word,
		output fetch_pc,
		output kill
	);

	// output capture
	modport latch (
		input ack_fire,
		input bus_word,
		input fetch_pc,
		input kill,
		input fetch_done
	);

endinterface

`default_nettype wire

/* rtl/fetch_pkg.sv */
// instruction fetch shared definitions
`default_nettype none

package fetch_pkg;

	// data and address width, one word
	localparam int XLEN = 32;

	// first fetch address after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
	// sequential increment, one instruction
	localparam logic [XLEN-1:0] PC_STEP = 32'd4;

	// opcodes the fetch stage decodes itself
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;

	// wait cycles with stb high and no ack before a retry
	localparam int BUS_TIMEOUT = 8;
	localparam int TIMER_W = 4;

	// fetch machine states
	// drop is the one-cycle gap before a retry
	localparam logic [1:0] ST_IDLE = 2'b00;
	localparam logic [1:0] ST_REQ = 2'b01;
	localparam logic [1:0] ST_DROP = 2'b10;
	localparam logic [1:0] ST_DONE = 2'b11;

	// one instruction word, read as j-type or i-type
	typedef union packed {
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_view;
		struct packed {
			logic [11:0] imm11_0;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_view;
	} inst_word_u;

endpackage

`default_nettype wire

/* rtl/fetch_top.sv */
// instruction fetch top level
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            stall,
	input  logic            redirect_valid,
	input  logic [XLEN-1:0] redirect_addr,
	input  logic [XLEN-1:0] reg_in,
	input  logic            ack,
	input  logic [XLEN-1:0] dat_i,
	output logic            cyc,
	output logic            stb,
	output logic [XLEN-1:0] adr,
	output logic [XLEN-1:0] inst,
	output logic [XLEN-1:0] inst_pc,
	output logic            inst_valid,
	output logic [XLEN-1:0] pc_next
);

	logic timer_run;
	logic timer_expired;

	fetch_ctl_if ctl ();

	// read data goes straight onto the shared bundle
	assign ctl.bus_word = dat_i;
	// request address is always the current pc
	assign adr = ctl.fetch_pc;

	bus_fetch_fsm u_fsm (
		.clk           (clk),
		.rst           (rst),
		.stall         (stall),
		.ack           (ack),
		.timer_expired (timer_expired),
		.timer_run     (timer_run),
		.cyc           (cyc),
		.stb           (stb),
		.ctl           (ctl.fsm)
	);

	// retry timer for a slow or missing ack
	bus_wait_timer u_timer (
		.clk     (clk),
		.rst     (rst),
		.run     (timer_run),
		.expired (timer_expired)
	);

	pc_unit u_pc (
		.clk            (clk),
		.rst            (rst),
		.redirect_valid (redirect_valid),
		.redirect_addr  (redirect_addr),
		.reg_in         (reg_in),
		.pc_next        (pc_next),
		.ctl            (ctl.pc)
	);

	inst_latch u_latch (
		.clk        (clk),
		.rst        (rst),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.inst_valid (inst_valid),
		.ctl        (ctl.latch)
	);

endmodule

`default_nettype wire

/* rtl/inst_latch.sv */
// fetched instruction latch
`timescale 1ns/1ps
`default_nettype none

module inst_latch import fetch_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	output logic [XLEN-1:0] inst,
	output logic [XLEN-1:0] inst_pc,
	output logic            inst_valid,
	fetch_ctl_if.latch      ctl
);

	logic [XLEN-1:0] word_q;
	logic [XLEN-1:0] pc_q;
	logic            kill_q;

	// word and its address, taken at the ack edge
	always_ff @(posedge clk) begin
		if (ctl.ack_fire) begin
			word_q <= ctl.bus_word;
			pc_q <= ctl.fetch_pc;
		end
	end

	// kill flag travels with the word
	always_ff @(posedge clk) begin
		if (rst) begin
			kill_q <= 1'b0;
		end else if (ctl.ack_fire) begin
			kill_q <= ctl.kill;
		end
	end

	assign inst = word_q;
	assign inst_pc = pc_q;
	// valid only in the done cycle, and not for a redirected fetch
	assign inst_valid = ctl.fetch_done & ~kill_q;

endmodule

`default_nettype wire

/* rtl/pc_unit.sv */
// program counter and next pc select
`timescale 1ns/1ps
`default_nettype none

module pc_unit import fetch_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            redirect_valid,
	input  logic [XLEN-1:0] redirect_addr,
	input  logic [XLEN-1:0] reg_in,
	output logic [XLEN-1:0] pc_next,
	fetch_ctl_if.pc         ctl
);

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] link_pc;
	logic            redir_pend;
	logic [XLEN-1:0] redir_addr;
	logic            redir_now;
	logic [XLEN-1:0] redir_tgt;
	inst_word_u      word;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] seq_pc;
	logic [XLEN-1:0] jal_tgt;
	logic [XLEN-1:0] jalr_tgt;
	logic [XLEN-1:0] pc_sel;

	// pending redirect, consumed by the next ack
	always_ff @(posedge clk) begin
		if (rst) begin
			redir_pend <= 1'b0;
		end else if (ctl.ack_fire) begin
			redir_pend <= 1'b0;
		end else if (redirect_valid) begin
			redir_pend <= 1'b1;
		end
	end

	// redirect target, last pulse wins
	always_ff @(posedge clk) begin
		if (redirect_valid) begin
			redir_addr <= redirect_addr;
		end
	end

	// a pulse in the ack cycle itself still counts
	assign redir_now = redir_pend | redirect_valid;
	assign redir_tgt = redirect_valid ? redirect_addr : redir_addr;

	// decode the returned word both ways
	assign word = ctl.bus_word;

	// j immediate, bit 0 implied zero
	assign imm_j = {{11{word.j_view.imm20}}, word.j_view.imm20, word.j_view.imm19_12,
		word.j_view.imm11, word.j_view.imm10_1, 1'b0};
	// i immediate, sign extended
	assign imm_i = {{20{word.i_view.imm11_0[11]}}, word.i_view.imm11_0};

	assign seq_pc = pc + PC_STEP;
	assign jal_tgt = pc + imm_j;
	// jalr clears bit 0 of the sum
	assign jalr_tgt = (reg_in + imm_i) & ~32'd1;

	// priority: redirect, jal, jalr, sequential
	always_comb begin
		if (redir_now) begin
			pc_sel = redir_tgt;
		end else if (word.j_view.opcode == OP_JAL) begin
			pc_sel = jal_tgt;
		end else if (word.i_view.opcode == OP_JALR) begin
			pc_sel = jalr_tgt;
		end else begin
			pc_sel = seq_pc;
		end
	end

	// pc and link address move together at the ack edge
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
			link_pc <= RESET_PC + PC_STEP;
		end else if (ctl.ack_fire) begin
			pc <= pc_sel;
			link_pc <= seq_pc;
		end
	end

	// sequential address of the word just fetched
	assign pc_next = link_pc;

	assign ctl.fetch_pc = pc;
	// redirected fetch is dropped downstream
	assign ctl.kill = ctl.ack_fire & redir_now;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module tb_fetch \
	-f filelist.f --Mdir obj_dir -o sim_fetch; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_fetch 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* tb/fetch_input.txt */
// hex columns word ack_delay redirect redirect_addr reg_in stall_cycles
// an ack_delay at or above the bus timeout withholds ack until the retry
00000013 00 0 00000000 00000000 00
00100093 02 0 00000000 00000000 00
00208133 01 0 00000000 00000000 03
020000ef 00 0 00000000 00000000 00
00300193 03 0 00000000 00000000 00
00828067 01 0 00000000 00000101 00
00400213 07 0 00000000 00000000 00
00500293 08 0 00000000 00000000 00
00600313 02 1 00000400 00000000 00
f01ff06f 00 0 00000000 00000000 00
ffc100e7 00 0 00000000 00000205 02
00700393 09 1 00000800 00000000 00
00800413 04 0 00000000 00000000 01
00008067 01 0 00000000 00000a01 00
0100006f 01 1 00000c00 00000000 00
0100006f 02 0 00000000 00000000 00
00900493 0c 0 00000000 00000000 00
00a00513 00 0 00000000 00000000 04
00b00593 01 0 00000000 ffffffff 00
00c00613 05 0 00000000 00000000 00

/* tb/tb_fetch.sv */
// instruction fetch testbench
`timescale 1ns/1ps
`default_nettype none

module tb_fetch import fetch_pkg::*; ();

	localparam int N_LINES = 20;
	localparam int N_FIELDS = 6;
	localparam int CLK_HALF = 2;
	localparam int WATCHDOG_CYCLES = 40 * N_LINES + 100;

	logic            clk;
	logic            rst;
	logic            stall;
	logic            redirect_valid;
	logic [XLEN-1:0] redirect_addr;
	logic [XLEN-1:0] reg_in;
	logic            ack;
	logic [XLEN-1:0] dat_i;
	logic            cyc;
	logic            stb;
	logic [XLEN-1:0] adr;
	logic [XLEN-1:0] inst;
	logic [XLEN-1:0] inst_pc;
	logic            inst_valid;
	logic [XLEN-1:0] pc_next;

	// trace memory, six fields per fetch
	logic [XLEN-1:0] trace [0:N_LINES*N_FIELDS-1];
	// reference pc of the next request
	logic [XLEN-1:0] exp_pc;
	int              valid_seen;

	fetch_top UUT (
		.clk            (clk),
		.rst            (rst),
		.stall          (stall),
		.redirect_valid (redirect_valid),
		.redirect_addr  (redirect_addr),
		.reg_in         (reg_in),
		.ack            (ack),
		.dat_i          (dat_i),
		.cyc            (cyc),
		.stb            (stb),
		.adr            (adr),
		.inst           (inst),
		.inst_pc        (inst_pc),
		.inst_valid     (inst_valid),
		.pc_next        (pc_next)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	task automatic stop_failed();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic abort_run(input string reason);
		$display("ERROR at %0t ns: %s", $time, reason);
		stop_failed();
	endtask

	task automatic check_addr(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, want);
			stop_failed();
		end
	endtask

	task automatic check_word(input string name, input inst_word_u got, input inst_word_u want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, want);
			stop_failed();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, want);
			stop_failed();
		end
	endtask

	// inputs change 1 ns after the edge, outputs are settled there
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// reference next pc in priority order
	function automatic logic [XLEN-1:0] expect_target(input logic [XLEN-1:0] pc,
		input inst_word_u w, input logic redir, input logic [XLEN-1:0] redir_to,
		input logic [XLEN-1:0] reg_val);
		logic signed [20:0] j_off;
		logic signed [11:0] i_off;
		j_off = {w.j_view.imm20, w.j_view.imm19_12, w.j_view.imm11, w.j_view.imm10_1, 1'b0};
		i_off = w.i_view.imm11_0;
		if (redir) begin
			return redir_to;
		end
		if (w.j_view.opcode == OP_JAL) begin
			return pc + XLEN'(j_off);
		end
		if (w.i_view.opcode == OP_JALR) begin
			return (reg_val + XLEN'(i_off)) & 32'hffff_fffe;
		end
		return pc + PC_STEP;
	endfunction

	// one trace line: stall, request, bus answer, done cycle
	task automatic fetch_line(input int idx, input bit first);
		inst_word_u      word;
		logic [XLEN-1:0] delay;
		logic            redir;
		logic [XLEN-1:0] redir_to;
		logic [XLEN-1:0] reg_val;
		logic [XLEN-1:0] req_pc;
		logic [XLEN-1:0] exp_next;
		int              n_stall;
		int              exp_gap;
		int              gap;
		int              waited;
		int              answer_at;
		bit              started;
		bit              acked;

		word = trace[idx*N_FIELDS];
		delay = trace[idx*N_FIELDS+1];
		redir = trace[idx*N_FIELDS+2][0];
		redir_to = trace[idx*N_FIELDS+3];
		reg_val = trace[idx*N_FIELDS+4];
		n_stall = int'(trace[idx*N_FIELDS+5]);
		req_pc = exp_pc;

		// idle is one cycle, or as long as stall holds
		reg_in = reg_val;
		stall = (n_stall != 0);
		if (n_stall != 0) begin
			exp_gap = n_stall + 1;
		end else begin
			exp_gap = first ? 1 : 2;
		end
		gap = 0;
		started = 1'b0;
		while (!started) begin
			next_cycle();
			gap++;
			if (stb) begin
				if (gap != exp_gap) begin
					abort_run($sformatf("request %0d started after %0d cycles, expected %0d",
						idx, gap, exp_gap));
				end
				started = 1'b1;
			end else begin
				check_flag("inst_valid", inst_valid, 1'b0);
				check_addr("adr", adr, req_pc);
				if (gap >= exp_gap) begin
					abort_run($sformatf("stb did not rise for request %0d", idx));
				end
			end
			if (gap == n_stall) begin
				stall = 1'b0;
			end
		end

		// request on the bus, redirect pulsed in its first cycle
		check_flag("cyc", cyc, 1'b1);
		check_addr("adr", adr, req_pc);
		redirect_valid = redir;
		redirect_addr = redir_to;
		answer_at = (delay >= BUS_TIMEOUT) ? -1 : int'(delay);
		waited = 0;
		acked = 1'b0;
		while (!acked) begin
			acked = (waited == answer_at);
			ack = acked;
			dat_i = acked ? word : ~word;
			next_cycle();
			redirect_valid = 1'b0;
			waited++;
			if (!acked) begin
				check_flag("inst_valid", inst_valid, 1'b0);
				if (!stb) begin
					// dropped by the wait timer
					if (answer_at >= 0) begin
						abort_run("stb dropped while an ack was still due");
					end
					if (waited != BUS_TIMEOUT) begin
						abort_run($sformatf("stb dropped after %0d wait cycles, expected %0d",
							waited, BUS_TIMEOUT));
					end
					check_flag("cyc", cyc, 1'b0);
					// stray ack while stb is low
					ack = 1'b1;
					next_cycle();
					ack = 1'b0;
					check_flag("stb", stb, 1'b1);
					check_addr("adr", adr, req_pc);
					answer_at = 0;
					waited = 0;
				end else begin
					check_addr("adr", adr, req_pc);
					if (waited >= BUS_TIMEOUT) begin
						abort_run("stb held past the bus timeout");
					end
				end
			end
		end
		ack = 1'b0;
		dat_i = '0;

		// done cycle
		exp_next = expect_target(req_pc, word, redir, redir_to, reg_val);
		check_flag("stb", stb, 1'b0);
		check_flag("inst_valid", inst_valid, !redir);
		if (!redir) begin
			check_word("inst", inst, word);
			check_addr("inst_pc", inst_pc, req_pc);
		end
		check_addr("pc_next", pc_next, req_pc + PC_STEP);
		check_addr("adr", adr, exp_next);
		exp_pc = exp_next;
	endtask

	// count delivered words where outputs are stable
	initial begin
		valid_seen = 0;
		forever begin
			@(negedge clk);
			if (inst_valid === 1'b1) begin
				valid_seen++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("watchdog expired before the trace finished");
	end

	initial begin
		int n_expected;
		int i;
		rst = 1'b1;
		stall = 1'b0;
		redirect_valid = 1'b0;
		redirect_addr = '0;
		reg_in = '0;
		ack = 1'b0;
		dat_i = '0;
		exp_pc = RESET_PC;
		$readmemh("tb/fetch_input.txt", trace);
		// redirected words are never delivered
		n_expected = 0;
		for (i = 0; i < N_LINES; i++) begin
			if (trace[i*N_FIELDS+2][0] == 1'b0) begin
				n_expected++;
			end
		end

		repeat (10) next_cycle();
		check_flag("cyc", cyc, 1'b0);
		check_flag("stb", stb, 1'b0);
		check_flag("inst_valid", inst_valid, 1'b0);
		check_addr("adr", adr, RESET_PC);
		rst = 1'b0;

		for (i = 0; i < N_LINES; i++) begin
			fetch_line(i, i == 0);
		end
		// inst_valid is a single cycle pulse
		next_cycle();
		check_flag("inst_valid", inst_valid, 1'b0);

		if (valid_seen == n_expected) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("ERROR: %0d words delivered, expected %0d", valid_seen, n_expected);
			stop_failed();
		end
	end

endmodule

`default_nettype wire
